// File: conv_top.f
source/conv_mem_pkg.sv
source/conv_calc_pkg.sv
source/conv_ctrl.sv
source/conv_window.sv
source/mismatch_tree.sv
source/row_assembler.sv
source/conv_top.sv
tests/tb_clock.sv
tests/conv_top_tb.sv

// File: tests/conv_top_tb.sv
// testbench for conv_top: memory models, random images, reference model and pass or fail report
module conv_top_tb
	import conv_mem_pkg::*;
	import conv_calc_pkg::*;
;

	localparam int mem_depth = 4096;
	localparam int wait_limit = 5000;

	logic clk;
	logic reset_b;
	logic dut_run;
	logic dut_busy;
	mem_addr_t dut_sram_read_address;
	mem_word_t sram_dut_read_data;
	mem_addr_t dut_wmem_read_address;
	mem_word_t wmem_dut_read_data;
	mem_addr_t dut_sram_write_address;
	mem_word_t dut_sram_write_data;
	logic dut_sram_write_enable;

	// input and weight memory contents
	mem_word_t in_mem [mem_depth];
	mem_word_t wmem [mem_depth];

	// writes seen on the output port, in order
	mem_addr_t wr_addr_q [$];
	mem_word_t wr_data_q [$];
	// model rows and their column counts
	mem_word_t exp_data_q [$];
	int exp_cols_q [$];

	// next free input word while building a run
	int build_ptr;

	mem_addr_t rd_addr_s;
	mem_addr_t w_addr_s;

	tb_clock u_clock (
		.clk     (clk),
		.reset_b (reset_b)
	);

	conv_top #(
		.addr_width (12)
	) u_dut (
		.clk                    (clk),
		.reset_b                (reset_b),
		.dut_run                (dut_run),
		.dut_busy               (dut_busy),
		.dut_sram_read_address  (dut_sram_read_address),
		.sram_dut_read_data     (sram_dut_read_data),
		.dut_wmem_read_address  (dut_wmem_read_address),
		.wmem_dut_read_data     (wmem_dut_read_data),
		.dut_sram_write_address (dut_sram_write_address),
		.dut_sram_write_data    (dut_sram_write_data),
		.dut_sram_write_enable  (dut_sram_write_enable)
	);

	// both memories answer one cycle after the address
	always @(posedge clk) begin
		rd_addr_s = dut_sram_read_address;
		w_addr_s = dut_wmem_read_address;
		#2;
		sram_dut_read_data = in_mem[rd_addr_s];
		wmem_dut_read_data = wmem[w_addr_s];
	end

	// output memory, logs every write
	always @(posedge clk) begin
		if (dut_sram_write_enable) begin
			wr_addr_q.push_back(dut_sram_write_address);
			wr_data_q.push_back(dut_sram_write_data);
		end
	end

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input mem_word_t got, input mem_word_t exp);
		if (got !== exp) begin
			fail_now($sformatf("Error at time %0t: %s expected %h got %h", $time, name, exp, got));
		end
	endtask

	task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp) begin
			fail_now($sformatf("Error at time %0t: %s expected %h got %h", $time, name, exp, got));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			fail_now($sformatf("Error at time %0t: %s expected %0d got %0d", $time, name, exp, got));
		end
	endtask

	// fresh memories and empty queues, input starts at word 0
	task automatic clear_run();
		wr_addr_q.delete();
		wr_data_q.delete();
		exp_data_q.delete();
		exp_cols_q.delete();
		build_ptr = 0;
		for (int a = 0; a < mem_depth; a++) begin
			in_mem[a] = mem_word_t'(a * 40503 + 16'h0f0f);
			wmem[a] = mem_word_t'(a * 9973 + 16'h3c5a);
		end
	endtask

	task automatic set_kernel(input mem_word_t value);
		wmem[weight_addr] = value;
	endtask

	// one image into input memory, model rows into the expected queue
	task automatic add_image(input int rows, input int cols);
		mem_word_t img [16];
		mem_word_t word;
		kernel_bits_t kern;
		int cnt;
		kern = kernel_bits_t'(wmem[weight_addr]);
		in_mem[build_ptr] = mem_word_t'(rows);
		in_mem[build_ptr+1] = mem_word_t'(cols);
		build_ptr += 2;
		// bits above cols are random too, the engine must ignore them
		for (int r = 0; r < rows; r++) begin
			img[r] = mem_word_t'($urandom);
			in_mem[build_ptr] = img[r];
			build_ptr++;
		end
		for (int r = 0; r <= rows - 3; r++) begin
			word = '0;
			for (int j = 0; j <= cols - 3; j++) begin
				cnt = 0;
				for (int i = 0; i < 3; i++) begin
					for (int k = 0; k < 3; k++) begin
						cnt += int'(img[r+i][j+k] ^ kern[i*3+k]);
					end
				end
				word[j] = (cnt <= 4);
			end
			exp_data_q.push_back(word);
			exp_cols_q.push_back(cols);
		end
	endtask

	task automatic append_end_marker();
		in_mem[build_ptr] = end_marker;
		build_ptr++;
	endtask

	// run level until busy rises, then wait for the run to finish
	task automatic pulse_run();
		int n;
		dut_run = 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!dut_busy && n < wait_limit);
		if (!dut_busy) begin
			fail_now("timeout waiting for busy to rise after run");
		end
		check_count("cycles from run to busy", n, 1);
		#1 dut_run = 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (dut_busy && n < wait_limit);
		if (dut_busy) begin
			fail_now($sformatf("timeout waiting for busy to fall, controller in %s",
				u_dut.u_ctrl.state.name()));
		end
	endtask

	task automatic compare_writes();
		mem_word_t high_mask;
		check_count("write count", wr_data_q.size(), exp_data_q.size());
		foreach (exp_data_q[i]) begin
			// output rows count up from 0 across all images
			check_addr("dut_sram_write_address", wr_addr_q[i], mem_addr_t'(i));
			high_mask = ~((16'd1 << (exp_cols_q[i] - 2)) - 16'd1);
			check_word("dut_sram_write_data bits above cols-2", wr_data_q[i] & high_mask, '0);
			check_word("dut_sram_write_data", wr_data_q[i], exp_data_q[i]);
		end
	endtask

	function automatic int random_size();
		return 3 + int'($urandom % 14);
	endfunction

	initial begin
		int n;
		dut_run = 1'b0;
		sram_dut_read_data = '0;
		wmem_dut_read_data = '0;
		void'($urandom(32'hda71));
		clear_run();

		n = 0;
		while (reset_b !== 1'b1 && n < wait_limit) begin
			@(posedge clk);
			n++;
		end
		if (reset_b !== 1'b1) begin
			fail_now("timeout waiting for reset release");
		end
		@(posedge clk);
		#2;
		check_word("dut_sram_write_enable after reset", mem_word_t'(dut_sram_write_enable), '0);
		check_word("dut_busy after reset", mem_word_t'(dut_busy), '0);

		// single random image
		clear_run();
		set_kernel(mem_word_t'($urandom));
		add_image(random_size(), random_size());
		append_end_marker();
		pulse_run();
		compare_writes();

		// three images back to back in one run
		clear_run();
		set_kernel(mem_word_t'($urandom));
		for (int m = 0; m < 3; m++) begin
			add_image(random_size(), random_size());
		end
		append_end_marker();
		pulse_run();
		compare_writes();

		// end marker only, no writes
		clear_run();
		set_kernel(mem_word_t'($urandom));
		append_end_marker();
		pulse_run();
		compare_writes();

		// smallest and largest images, all-ones then all-zeros kernel
		clear_run();
		set_kernel(16'h01ff);
		add_image(3, 3);
		add_image(16, 16);
		append_end_marker();
		pulse_run();
		compare_writes();
		clear_run();
		set_kernel(16'h0000);
		add_image(16, 16);
		add_image(3, 3);
		append_end_marker();
		pulse_run();
		compare_writes();

		// two runs in a row, each starts from address 0
		for (int m = 0; m < 2; m++) begin
			clear_run();
			set_kernel(mem_word_t'($urandom));
			add_image(random_size(), random_size());
			add_image(random_size(), random_size());
			append_end_marker();
			pulse_run();
			compare_writes();
		end

		repeat (3) @(posedge clk);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: tests/tb_clock.sv
// testbench clock and reset source, 40 unit period with reset held low for five cycles
module tb_clock (
	output logic clk,
	output logic reset_b
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// release a little after the edge, like every other driven input
	initial begin
		reset_b = 1'b0;
		repeat (5) @(posedge clk);
		#2 reset_b = 1'b1;
	end

endmodule

// File: source/conv_top.sv
// top level of the binary 3x3 convolution engine, wires the blocks to the memory ports
module conv_top
	import conv_mem_pkg::*;
	import conv_calc_pkg::*;
#(
	parameter int addr_width = 12
) (
	input  logic      clk,
	input  logic      reset_b,
	input  logic      dut_run,
	output logic      dut_busy,
	output mem_addr_t dut_sram_read_address,
	input  mem_word_t sram_dut_read_data,
	output mem_addr_t dut_wmem_read_address,
	input  mem_word_t wmem_dut_read_data,
	output mem_addr_t dut_sram_write_address,
	output mem_word_t dut_sram_write_data,
	output logic      dut_sram_write_enable
);

	// controller to window
	logic load_kernel;
	kernel_bits_t kernel;
	logic shift;
	logic [kernel_dim-1:0] col_bits;
	col_idx_t col_idx;
	logic col_valid;
	logic row_end;
	mem_addr_t out_addr;

	// window to adder tree
	logic [kernel_dim*kernel_dim-1:0] mismatch;
	logic tag_valid;
	col_idx_t tag_idx;
	logic tag_row_end;
	mem_addr_t tag_addr;

	// adder tree to row assembler
	logic res_bit;
	logic res_valid;
	col_idx_t res_idx;
	logic res_row_end;
	mem_addr_t res_addr;

	logic row_done;

	conv_ctrl #(
		.addr_width (addr_width)
	) u_ctrl (
		.clk         (clk),
		.reset_b     (reset_b),
		.run         (dut_run),
		.busy        (dut_busy),
		.rd_addr     (dut_sram_read_address),
		.rd_data     (sram_dut_read_data),
		.w_addr      (dut_wmem_read_address),
		.w_data      (wmem_dut_read_data),
		.row_done    (row_done),
		.load_kernel (load_kernel),
		.kernel      (kernel),
		.shift       (shift),
		.col_bits    (col_bits),
		.col_idx     (col_idx),
		.col_valid   (col_valid),
		.row_end     (row_end),
		.out_addr    (out_addr)
	);

	conv_window u_window (
		.clk         (clk),
		.reset_b     (reset_b),
		.load_kernel (load_kernel),
		.kernel      (kernel),
		.shift       (shift),
		.col_bits    (col_bits),
		.col_idx     (col_idx),
		.col_valid   (col_valid),
		.row_end     (row_end),
		.out_addr    (out_addr),
		.mismatch    (mismatch),
		.tag_valid   (tag_valid),
		.tag_idx     (tag_idx),
		.tag_row_end (tag_row_end),
		.tag_addr    (tag_addr)
	);

	mismatch_tree u_tree (
		.clk         (clk),
		.reset_b     (reset_b),
		.mismatch    (mismatch),
		.tag_valid   (tag_valid),
		.tag_idx     (tag_idx),
		.tag_row_end (tag_row_end),
		.tag_addr    (tag_addr),
		.res_bit     (res_bit),
		.res_valid   (res_valid),
		.res_idx     (res_idx),
		.res_row_end (res_row_end),
		.res_addr    (res_addr)
	);

	row_assembler #(
		.addr_width (addr_width)
	) u_assembler (
		.clk         (clk),
		.reset_b     (reset_b),
		.res_bit     (res_bit),
		.res_valid   (res_valid),
		.res_idx     (res_idx),
		.res_row_end (res_row_end),
		.res_addr    (res_addr),
		.wr_addr     (dut_sram_write_address),
		.wr_data     (dut_sram_write_data),
		.wr_en       (dut_sram_write_enable),
		.row_done    (row_done)
	);

	// controller drains the pipeline before dropping busy
	a_write_while_busy: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |-> dut_busy);

endmodule

// File: source/row_assembler.sv
// builds one output word from result bits and writes it to output memory at row end
module row_assembler
	import conv_mem_pkg::*;
	import conv_calc_pkg::*;
#(
	parameter int addr_width = 12
) (
	input  logic      clk,
	input  logic      reset_b,
	input  logic      res_bit,
	input  logic      res_valid,
	input  col_idx_t  res_idx,
	input  logic      res_row_end,
	input  mem_addr_t res_addr,
	output mem_addr_t wr_addr,
	output mem_word_t wr_data,
	output logic      wr_en,
	output logic      row_done
);

	// row under construction, unused high bits stay 0
	mem_word_t word;
	// address of the row being written
	logic [addr_width-1:0] addr_q;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			word <= '0;
			wr_en <= 1'b0;
		end else begin
			// write goes out the cycle after the last bit
			wr_en <= res_row_end;
			if (wr_en) begin
				// next row bits arrive no sooner than three cycles later
				word <= '0;
			end else if (res_valid) begin
				word[res_idx] <= res_bit;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (res_row_end) begin
			addr_q <= addr_width'(res_addr);
		end
	end

	assign wr_addr = mem_addr_t'(addr_q);
	assign wr_data = word;
	// controller counts finished rows with this
	assign row_done = wr_en;

	a_single_write: assert property (@(posedge clk) disable iff (!reset_b)
		wr_en |=> !wr_en);

endmodule

// File: source/mismatch_tree.sv
// two registered full-adder stages deciding per column whether mismatches stay within the limit
module mismatch_tree
	import conv_mem_pkg::*;
	import conv_calc_pkg::*;
(
	input  logic                             clk,
	input  logic                             reset_b,
	input  logic [kernel_dim*kernel_dim-1:0] mismatch,
	input  logic                             tag_valid,
	input  col_idx_t                         tag_idx,
	input  logic                             tag_row_end,
	input  mem_addr_t                        tag_addr,
	output logic                             res_bit,
	output logic                             res_valid,
	output col_idx_t                         res_idx,
	output logic                             res_row_end,
	output mem_addr_t                        res_addr
);

	// {carry, sum}
	function automatic logic [1:0] full_add(input logic a, input logic b, input logic c);
		return {(a & b) | (a & c) | (b & c), a ^ b ^ c};
	endfunction

	logic [1:0] s1_fa [kernel_dim];
	logic [kernel_dim-1:0] s1_ones;
	logic [kernel_dim-1:0] s1_twos;
	logic s1_valid;
	logic s1_row_end;
	col_idx_t s1_idx;
	mem_addr_t s1_addr;

	logic [1:0] s2_lo;
	logic [1:0] s2_hi;
	// weights 1, 2, 2, 4
	logic ones;
	logic twos_a;
	logic twos_b;
	logic fours;
	logic s2_valid;
	logic s2_row_end;
	col_idx_t s2_idx;
	mem_addr_t s2_addr;

	logic [3:0] count;

	// stage 1, one adder per kernel row
	always_comb begin
		for (int i = 0; i < kernel_dim; i++) begin
			s1_fa[i] = full_add(mismatch[i*kernel_dim], mismatch[i*kernel_dim+1],
				mismatch[i*kernel_dim+2]);
		end
	end

	// stage 2, ones column and twos column
	assign s2_lo = full_add(s1_ones[0], s1_ones[1], s1_ones[2]);
	assign s2_hi = full_add(s1_twos[0], s1_twos[1], s1_twos[2]);

	always_ff @(posedge clk) begin
		for (int i = 0; i < kernel_dim; i++) begin
			s1_ones[i] <= s1_fa[i][0];
			s1_twos[i] <= s1_fa[i][1];
		end
		s1_idx <= tag_idx;
		s1_addr <= tag_addr;
		ones <= s2_lo[0];
		twos_a <= s2_lo[1];
		twos_b <= s2_hi[0];
		fours <= s2_hi[1];
		s2_idx <= s1_idx;
		s2_addr <= s1_addr;
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			s1_valid <= 1'b0;
			s1_row_end <= 1'b0;
			s2_valid <= 1'b0;
			s2_row_end <= 1'b0;
		end else begin
			s1_valid <= tag_valid;
			s1_row_end <= tag_row_end;
			s2_valid <= s1_valid;
			s2_row_end <= s1_row_end;
		end
	end

	// total mismatches, 0 to 9
	assign count = {3'b000, ones} + {2'b00, twos_a, 1'b0} + {2'b00, twos_b, 1'b0} +
		{1'b0, fours, 2'b00};
	assign res_bit = (count <= mismatch_limit);
	assign res_valid = s2_valid;
	assign res_idx = s2_idx;
	assign res_row_end = s2_row_end;
	assign res_addr = s2_addr;

	// output index stays within a word minus the window overhang
	a_idx_in_word: assert property (@(posedge clk) disable iff (!reset_b)
		res_valid |-> (res_idx <= col_idx_t'($bits(mem_word_t) - kernel_dim)));

endmodule

// File: source/conv_window.sv
// 3x3 cell array: kernel bits against shifting input columns, gives nine mismatch bits plus tags
module conv_window
	import conv_mem_pkg::*;
	import conv_calc_pkg::*;
(
	input  logic                             clk,
	input  logic                             reset_b,
	input  logic                             load_kernel,
	input  kernel_bits_t                     kernel,
	input  logic                             shift,
	input  logic [kernel_dim-1:0]            col_bits,
	input  col_idx_t                         col_idx,
	input  logic                             col_valid,
	input  logic                             row_end,
	input  mem_addr_t                        out_addr,
	output logic [kernel_dim*kernel_dim-1:0] mismatch,
	output logic                             tag_valid,
	output col_idx_t                         tag_idx,
	output logic                             tag_row_end,
	output mem_addr_t                        tag_addr
);

	kernel_bits_t kernel_q;

	// per kernel row, bit 0 newest column
	logic [kernel_dim-1:0] chain [kernel_dim];

	always_ff @(posedge clk) begin
		if (load_kernel) begin
			kernel_q <= kernel;
		end
		if (shift) begin
			for (int i = 0; i < kernel_dim; i++) begin
				chain[i] <= {chain[i][kernel_dim-2:0], col_bits[i]};
			end
			// output column is the oldest column in the window
			tag_idx <= col_idx - col_idx_t'(kernel_dim - 1);
			tag_addr <= out_addr;
		end
	end

	// cell (i,k) sees column j+k, which sits kernel_dim-1-k deep
	always_comb begin
		for (int i = 0; i < kernel_dim; i++) begin
			for (int k = 0; k < kernel_dim; k++) begin
				mismatch[i*kernel_dim+k] = chain[i][kernel_dim-1-k] ^ kernel_q[i*kernel_dim+k];
			end
		end
	end

	// tags line up with the chains one cycle after shift
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			tag_valid <= 1'b0;
			tag_row_end <= 1'b0;
		end else begin
			tag_valid <= shift && col_valid;
			tag_row_end <= shift && row_end;
		end
	end

	// last column always has a full window, counts start at 3
	a_row_end_valid: assert property (@(posedge clk) disable iff (!reset_b)
		tag_row_end |-> tag_valid);

endmodule

// File: source/conv_ctrl.sv
// sequencing FSM: reads headers, kernel and rows, keeps the row buffer and sweeps columns
module conv_ctrl
	import conv_mem_pkg::*;
	import conv_calc_pkg::*;
#(
	parameter int addr_width = 12
) (
	input  logic                  clk,
	input  logic                  reset_b,
	input  logic                  run,
	output logic                  busy,
	output mem_addr_t             rd_addr,
	input  mem_word_t             rd_data,
	output mem_addr_t             w_addr,
	input  mem_word_t             w_data,
	input  logic                  row_done,
	output logic                  load_kernel,
	output kernel_bits_t          kernel,
	output logic                  shift,
	output logic [kernel_dim-1:0] col_bits,
	output col_idx_t              col_idx,
	output logic                  col_valid,
	output logic                  row_end,
	output mem_addr_t             out_addr
);

	ctrl_state_t state;
	ctrl_state_t state_next;

	// next input word to read, next output row to write
	logic [addr_width-1:0] in_ptr;
	logic [addr_width-1:0] out_ptr;

	col_idx_t col_cnt;
	col_idx_t col_last;
	// bottom row of the window
	logic [3:0] row_cnt;
	logic [3:0] row_last;

	// rows swept but not yet written
	logic [1:0] pending;

	// three-row rolling buffer, [0] is the top row
	mem_word_t row_buf [kernel_dim];

	logic last_col;
	logic last_row;
	logic fetch;

	assign last_col = (col_cnt == col_last);
	assign last_row = (row_cnt == row_last);

	// every cycle that consumes the word at in_ptr
	// next row is fetched on the last column so it lands in row shift
	// after the last row the next header is fetched from row shift instead
	assign fetch = (state == st_idle && run) || (state == st_hdr_rows) ||
		(state == st_hdr_cols) || (state == st_load0) || (state == st_load1) ||
		(state == st_sweep && last_col && !last_row) ||
		(state == st_row_shift && last_row);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (run) begin
					state_next = st_hdr_rows;
				end
			end
			st_hdr_rows: begin
				// end marker in place of a row count
				if (rd_data == end_marker) begin
					state_next = st_drain;
				end else begin
					state_next = st_hdr_cols;
				end
			end
			st_hdr_cols: state_next = st_load0;
			st_load0: state_next = st_load1;
			st_load1: state_next = st_load2;
			st_load2: state_next = st_sweep;
			st_sweep: begin
				if (last_col) begin
					state_next = st_row_shift;
				end
			end
			st_row_shift: begin
				// next image header follows with no gap
				if (last_row) begin
					state_next = st_hdr_rows;
				end else begin
					state_next = st_sweep;
				end
			end
			st_drain: begin
				if (pending == '0) begin
					state_next = st_idle;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= st_idle;
			in_ptr <= '0;
			out_ptr <= '0;
			col_cnt <= '0;
			col_last <= '0;
			row_cnt <= '0;
			row_last <= '0;
			pending <= '0;
		end else begin
			state <= state_next;
			if (fetch) begin
				in_ptr <= in_ptr + 1'b1;
			end
			case (state)
				// counts kept as last index
				st_hdr_rows: row_last <= rd_data[3:0] - 4'd1;
				st_hdr_cols: col_last <= col_idx_t'(rd_data[3:0] - 4'd1);
				st_load2: begin
					col_cnt <= '0;
					row_cnt <= 4'(kernel_dim - 1);
				end
				st_sweep: begin
					if (!last_col) begin
						col_cnt <= col_cnt + 1'b1;
					end
				end
				st_row_shift: begin
					col_cnt <= '0;
					row_cnt <= row_cnt + 1'b1;
					// output rows run on across images
					out_ptr <= out_ptr + 1'b1;
				end
				st_drain: begin
					// next run restarts both memories at 0
					if (pending == '0) begin
						in_ptr <= '0;
						out_ptr <= '0;
					end
				end
				default: ;
			endcase
			case ({shift && row_end, row_done})
				2'b10: pending <= pending + 1'b1;
				2'b01: pending <= pending - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			st_load0: row_buf[0] <= rd_data;
			st_load1: row_buf[1] <= rd_data;
			st_load2: row_buf[2] <= rd_data;
			st_row_shift: begin
				// read data is the next header on the last row
				if (!last_row) begin
					row_buf[0] <= row_buf[1];
					row_buf[1] <= row_buf[2];
					row_buf[2] <= rd_data;
				end
			end
			default: ;
		endcase
	end

	assign busy = (state != st_idle);
	assign rd_addr = mem_addr_t'(in_ptr);
	// kernel address never changes
	assign w_addr = weight_addr;
	assign load_kernel = (state == st_hdr_cols);
	assign kernel = kernel_bits_t'(w_data);

	assign shift = (state == st_sweep);
	assign col_bits = {row_buf[2][col_cnt], row_buf[1][col_cnt], row_buf[0][col_cnt]};
	assign col_idx = col_cnt;
	// window is full from the third column on
	assign col_valid = (col_cnt >= col_idx_t'(kernel_dim - 1));
	assign row_end = shift && last_col;
	assign out_addr = mem_addr_t'(out_ptr);

	a_col_in_range: assert property (@(posedge clk) disable iff (!reset_b)
		(state == st_sweep) |-> (col_cnt <= col_last));

endmodule

// File: source/conv_calc_pkg.sv
// kernel geometry, column index type, mismatch threshold and controller states for the engine
package conv_calc_pkg;

	// fixed kernel edge, 3x3 window
	localparam int kernel_dim = 3;

	// one bit per kernel cell, bit i*3+k is row i column k
	typedef logic [kernel_dim*kernel_dim-1:0] kernel_bits_t;

	// column or output bit index inside a 16-bit row
	typedef logic [3:0] col_idx_t;

	// highest mismatch count that still gives a 1
	localparam int unsigned mismatch_limit = 4;

	// controller states
	typedef enum logic [3:0] {
		st_idle,
		// row count word on read data
		st_hdr_rows,
		// column count on read data, kernel loaded
		st_hdr_cols,
		// first three rows into the buffer
		st_load0,
		st_load1,
		st_load2,
		// one column per cycle into the window
		st_sweep,
		// roll the buffer or move to next header
		st_row_shift,
		// wait for rows still in the pipeline
		st_drain
	} ctrl_state_t;

endpackage

// File: source/conv_mem_pkg.sv
// memory-side widths, word types and fixed addresses, imported by every block that touches the memories
package conv_mem_pkg;

	// data word of all three memories
	// rows, counts, kernel and output rows all fit one word
	typedef logic [15:0] mem_word_t;

	// word address, shared by input, weight and output memories
	typedef logic [11:0] mem_addr_t;

	// kernel word in weight memory
	// word 0 would hold kernel dims, unused with the fixed 3x3 kernel
	localparam mem_addr_t weight_addr = 12'd1;

	// row count that closes a run
	localparam mem_word_t end_marker = 16'h00FF;

endpackage
